// ==== logic/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

	// Channel widths shared by every block
	parameter int ID_WIDTH   = 4;
	parameter int ADDR_WIDTH = 32;
	parameter int DATA_WIDTH = 32;
	parameter int STRB_WIDTH = 4;
	parameter int LEN_WIDTH  = 4;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	// Write address channel without its ready
	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0]  len;
		logic [2:0]            size;
		axi_burst_e            burst;
		logic                  valid;
	} axi_aw_t;

	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
		logic                  last;
		logic                  valid;
	} axi_w_t;

	typedef struct packed {
		logic [ID_WIDTH-1:0] id;
		axi_resp_e           resp;
		logic                valid;
	} axi_b_t;

	// Read address has the same layout as write address
	typedef axi_aw_t axi_ar_t;

	typedef struct packed {
		logic [ID_WIDTH-1:0]   id;
		logic [DATA_WIDTH-1:0] data;
		axi_resp_e             resp;
		logic                  last;
		logic                  valid;
	} axi_r_t;

endpackage

`default_nettype wire

// ==== logic/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	// RAM controller states
	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		WDATA = 2'b01,
		WRESP = 2'b10,
		RDATA = 2'b11
	} ram_state_e;

	// Byte address bits below one 32-bit word
	parameter int WORD_LSB = 2;

endpackage

`default_nettype wire

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
	parameter int NUM_MASTERS = 2,
	localparam int GRANT_BITS = $clog2(NUM_MASTERS)
) (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  logic [NUM_MASTERS-1:0] req,
	input  logic                   release_grant,
	output logic                   busy,
	output logic [GRANT_BITS-1:0]  grant
);

	logic [GRANT_BITS-1:0] next_grant;
	logic                  found;

	// First requester after the last grant, in cyclic order
	always_comb begin
		int idx;
		next_grant = grant;
		found = 1'b0;
		for (int i = 1; i <= NUM_MASTERS; i++) begin
			idx = (int'(grant) + i) % NUM_MASTERS;
			if (!found && req[idx]) begin
				next_grant = GRANT_BITS'(idx);
				found = 1'b1;
			end
		end
	end

	// Grant is held until the owner's transaction completes
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			busy <= 1'b0;
			grant <= '0;
		end else if (!busy) begin
			if (found) begin
				busy <= 1'b1;
				grant <= next_grant;
			end
		end else if (release_grant) begin
			busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== logic/axi_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mux
	import axi_pkg::*;
#(
	parameter int NUM_MASTERS = 2
) (
	input  logic                   aclk,
	input  logic                   aresetn,

	// Requester side
	input  axi_aw_t                s_aw [NUM_MASTERS],
	input  axi_w_t                 s_w [NUM_MASTERS],
	input  axi_ar_t                s_ar [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] s_awready,
	output logic [NUM_MASTERS-1:0] s_wready,
	output logic [NUM_MASTERS-1:0] s_arready,
	output axi_b_t                 s_b [NUM_MASTERS],
	output axi_r_t                 s_r [NUM_MASTERS],
	input  logic [NUM_MASTERS-1:0] s_bready,
	input  logic [NUM_MASTERS-1:0] s_rready,

	// RAM side
	output axi_aw_t                m_aw,
	output axi_w_t                 m_w,
	output axi_ar_t                m_ar,
	input  logic                   m_awready,
	input  logic                   m_wready,
	input  logic                   m_arready,
	input  axi_b_t                 m_b,
	input  axi_r_t                 m_r,
	output logic                   m_bready,
	output logic                   m_rready
);

	localparam int GRANT_BITS = $clog2(NUM_MASTERS);

	logic [NUM_MASTERS-1:0] aw_req;
	logic [NUM_MASTERS-1:0] ar_req;
	logic [NUM_MASTERS-1:0] wr_sel;
	logic [NUM_MASTERS-1:0] rd_sel;
	logic                   wr_busy;
	logic                   rd_busy;
	logic [GRANT_BITS-1:0]  wr_grant;
	logic [GRANT_BITS-1:0]  rd_grant;
	logic                   wr_release;
	logic                   rd_release;

	// Requests from the address valids, one-hot select from the grants
	always_comb begin
		for (int i = 0; i < NUM_MASTERS; i++) begin
			aw_req[i] = s_aw[i].valid;
			ar_req[i] = s_ar[i].valid;
			wr_sel[i] = wr_busy && (wr_grant == GRANT_BITS'(i));
			rd_sel[i] = rd_busy && (rd_grant == GRANT_BITS'(i));
		end
	end

	// Paths release on B, and on the last R beat
	assign wr_release = m_b.valid & m_bready;
	assign rd_release = m_r.valid & m_rready & m_r.last;

	rr_arbiter #(
		.NUM_MASTERS(NUM_MASTERS)
	) wr_arb (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.req           (aw_req),
		.release_grant (wr_release),
		.busy          (wr_busy),
		.grant         (wr_grant)
	);

	rr_arbiter #(
		.NUM_MASTERS(NUM_MASTERS)
	) rd_arb (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.req           (ar_req),
		.release_grant (rd_release),
		.busy          (rd_busy),
		.grant         (rd_grant)
	);

	// Write path steering
	always_comb begin
		m_aw = s_aw[wr_grant];
		m_aw.valid = wr_busy & s_aw[wr_grant].valid;
		m_w = s_w[wr_grant];
		m_w.valid = wr_busy & s_w[wr_grant].valid;
		m_bready = wr_busy & s_bready[wr_grant];
		for (int i = 0; i < NUM_MASTERS; i++) begin
			s_awready[i] = wr_sel[i] & m_awready;
			s_wready[i] = wr_sel[i] & m_wready;
			// Payload fans out, only the owner sees valid
			s_b[i] = m_b;
			s_b[i].valid = wr_sel[i] & m_b.valid;
		end
	end

	// Read path steering
	always_comb begin
		m_ar = s_ar[rd_grant];
		m_ar.valid = rd_busy & s_ar[rd_grant].valid;
		m_rready = rd_busy & s_rready[rd_grant];
		for (int i = 0; i < NUM_MASTERS; i++) begin
			s_arready[i] = rd_sel[i] & m_arready;
			s_r[i] = m_r;
			s_r[i].valid = rd_sel[i] & m_r.valid;
		end
	end

endmodule

`default_nettype wire

// ==== logic/axi_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_ram
	import axi_pkg::*;
	import mem_pkg::*;
#(
	parameter int MEM_WORDS = 256
) (
	input  logic    aclk,
	input  logic    aresetn,
	input  axi_aw_t aw,
	input  axi_w_t  w,
	input  axi_ar_t ar,
	output logic    awready,
	output logic    wready,
	output logic    arready,
	output axi_b_t  b,
	output axi_r_t  r,
	input  logic    bready,
	input  logic    rready
);

	localparam int WADDR_BITS = $clog2(MEM_WORDS);

	ram_state_e            state;
	logic [ID_WIDTH-1:0]   id_q;
	logic [WADDR_BITS-1:0] addr_q;
	logic [LEN_WIDTH-1:0]  cnt_q;
	logic                  err_q;
	axi_resp_e             resp;
	logic                  aw_fire;
	logic                  ar_fire;
	logic                  w_fire;
	logic                  r_fire;
	logic                  b_fire;

	logic [DATA_WIDTH-1:0] mem [MEM_WORDS];

	// Byte address to word index, folded into the array
	function automatic logic [WADDR_BITS-1:0] word_index(input logic [ADDR_WIDTH-1:0] byte_addr);
		return WADDR_BITS'((byte_addr >> WORD_LSB) % MEM_WORDS);
	endfunction

	function automatic logic [WADDR_BITS-1:0] next_word(input logic [WADDR_BITS-1:0] addr);
		if (addr == WADDR_BITS'(MEM_WORDS - 1)) begin
			return '0;
		end else begin
			return addr + 1'b1;
		end
	endfunction

	// AW wins over AR when both arrive in IDLE
	assign awready = (state == IDLE);
	assign arready = (state == IDLE) & ~aw.valid;
	assign wready = (state == WDATA);

	assign aw_fire = aw.valid & awready;
	assign ar_fire = ar.valid & arready;
	assign w_fire = w.valid & wready;
	assign r_fire = r.valid & rready;
	assign b_fire = b.valid & bready;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (aw_fire) begin
						state <= WDATA;
					end else if (ar_fire) begin
						state <= RDATA;
					end
				end
				WDATA: begin
					if (w_fire && w.last) begin
						state <= WRESP;
					end
				end
				WRESP: begin
					if (b_fire) begin
						state <= IDLE;
					end
				end
				RDATA: begin
					if (r_fire && r.last) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Burst context, stepped one word per beat
	always_ff @(posedge aclk) begin
		if (aw_fire) begin
			id_q <= aw.id;
			addr_q <= word_index(aw.addr);
			cnt_q <= aw.len;
			err_q <= (aw.burst != INCR);
		end else if (ar_fire) begin
			id_q <= ar.id;
			addr_q <= word_index(ar.addr);
			cnt_q <= ar.len;
			err_q <= (ar.burst != INCR);
		end else if (w_fire || r_fire) begin
			addr_q <= next_word(addr_q);
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// Strobed byte writes, nothing stored for FIXED or WRAP
	always_ff @(posedge aclk) begin
		if (w_fire && !err_q) begin
			for (int i = 0; i < STRB_WIDTH; i++) begin
				if (w.strb[i]) begin
					mem[addr_q][8*i +: 8] <= w.data[8*i +: 8];
				end
			end
		end
	end

	assign resp = err_q ? SLVERR : OKAY;

	always_comb begin
		b.id = id_q;
		b.resp = resp;
		b.valid = (state == WRESP);
		r.id = id_q;
		r.data = err_q ? '0 : mem[addr_q];
		r.resp = resp;
		r.last = (cnt_q == '0);
		r.valid = (state == RDATA);
	end

endmodule

`default_nettype wire

// ==== logic/axi_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_sys
	import axi_pkg::*;
#(
	parameter int NUM_MASTERS = 2,
	parameter int MEM_WORDS   = 256
) (
	input  logic                   aclk,
	input  logic                   aresetn,
	input  axi_aw_t                s_aw [NUM_MASTERS],
	input  axi_w_t                 s_w [NUM_MASTERS],
	input  axi_ar_t                s_ar [NUM_MASTERS],
	input  logic [NUM_MASTERS-1:0] s_bready,
	input  logic [NUM_MASTERS-1:0] s_rready,
	output axi_b_t                 s_b [NUM_MASTERS],
	output axi_r_t                 s_r [NUM_MASTERS],
	output logic [NUM_MASTERS-1:0] s_awready,
	output logic [NUM_MASTERS-1:0] s_wready,
	output logic [NUM_MASTERS-1:0] s_arready
);

	// Mux to RAM channels
	axi_aw_t m_aw;
	axi_w_t  m_w;
	axi_ar_t m_ar;
	axi_b_t  m_b;
	axi_r_t  m_r;
	logic    m_awready;
	logic    m_wready;
	logic    m_arready;
	logic    m_bready;
	logic    m_rready;

	axi_mux #(
		.NUM_MASTERS(NUM_MASTERS)
	) mux0 (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.s_aw      (s_aw),
		.s_w       (s_w),
		.s_ar      (s_ar),
		.s_awready (s_awready),
		.s_wready  (s_wready),
		.s_arready (s_arready),
		.s_b       (s_b),
		.s_r       (s_r),
		.s_bready  (s_bready),
		.s_rready  (s_rready),
		.m_aw      (m_aw),
		.m_w       (m_w),
		.m_ar      (m_ar),
		.m_awready (m_awready),
		.m_wready  (m_wready),
		.m_arready (m_arready),
		.m_b       (m_b),
		.m_r       (m_r),
		.m_bready  (m_bready),
		.m_rready  (m_rready)
	);

	axi_ram #(
		.MEM_WORDS(MEM_WORDS)
	) ram0 (
		.aclk    (aclk),
		.aresetn (aresetn),
		.aw      (m_aw),
		.w       (m_w),
		.ar      (m_ar),
		.awready (m_awready),
		.wready  (m_wready),
		.arready (m_arready),
		.b       (m_b),
		.r       (m_r),
		.bready  (m_bready),
		.rready  (m_rready)
	);

endmodule

`default_nettype wire

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker
	import axi_pkg::*;
#(
	parameter int NUM_MASTERS = 2
) (
	input logic                   aclk,
	input logic                   aresetn,
	input axi_b_t                 s_b [NUM_MASTERS],
	input logic [NUM_MASTERS-1:0] s_bready,
	input axi_r_t                 s_r [NUM_MASTERS],
	input logic [NUM_MASTERS-1:0] s_rready
);

	// Expected responses per requester, in the order that requester sees them
	axi_b_t exp_b [NUM_MASTERS][$];
	axi_r_t exp_r [NUM_MASTERS][$];

	int total_errors = 0;
	int missing = 0;
	int errors_mark = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic alt_check = 1'b0;
	logic prev_alt = 1'b0;
	logic [ID_WIDTH-1:0] last_bid = '0;

	task automatic expect_b(input int m, input axi_b_t b);
		exp_b[m].push_back(b);
	endtask

	task automatic expect_r(input int m, input axi_r_t r);
		exp_r[m].push_back(r);
	endtask

	task automatic set_alternation(input logic on);
		alt_check = on;
	endtask

	task automatic check_b(input int i);
		axi_b_t want;
		if (exp_b[i].size() == 0) begin
			$display("Requester %0d received a write response that no test asked for", i);
			total_errors++;
		end else begin
			want = exp_b[i].pop_front();
			if (s_b[i].id !== want.id || s_b[i].resp !== want.resp) begin
				$display("Error at %0t: requester %0d B id %0h resp %0d, expected id %0h resp %0d",
					$time, i, s_b[i].id, s_b[i].resp, want.id, want.resp);
				total_errors++;
			end
		end
		// Round robin between two busy writers means the B ids take turns
		if (alt_check && prev_alt && s_b[i].id == last_bid) begin
			$display("Error at %0t: B id %0h granted twice in a row", $time, s_b[i].id);
			total_errors++;
		end
		last_bid = s_b[i].id;
		prev_alt = alt_check;
	endtask

	task automatic check_r(input int i);
		axi_r_t want;
		if (exp_r[i].size() == 0) begin
			$display("Requester %0d received a read beat that no test asked for", i);
			total_errors++;
		end else begin
			want = exp_r[i].pop_front();
			if (s_r[i].id !== want.id || s_r[i].data !== want.data ||
					s_r[i].resp !== want.resp || s_r[i].last !== want.last) begin
				$display("Error at %0t: requester %0d R id %0h data %h resp %0d last %0b",
					$time, i, s_r[i].id, s_r[i].data, s_r[i].resp, s_r[i].last);
				$display("Error at %0t: expected id %0h data %h resp %0d last %0b",
					$time, want.id, want.data, want.resp, want.last);
				total_errors++;
			end
		end
	endtask

	// Handshakes as seen on the requester side
	always @(posedge aclk) begin
		if (aresetn) begin
			for (int i = 0; i < NUM_MASTERS; i++) begin
				if (s_b[i].valid && s_bready[i]) begin
					check_b(i);
				end
				if (s_r[i].valid && s_rready[i]) begin
					check_r(i);
				end
			end
		end
	end

	task automatic end_test(input string name);
		int left;
		left = 0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			left += exp_b[i].size() + exp_r[i].size();
			exp_b[i].delete();
			exp_r[i].delete();
		end
		tests_run++;
		if (left != 0) begin
			$display("Test %0d %s: %0d expected responses never arrived", tests_run, name, left);
			missing += left;
		end
		if (left != 0 || total_errors != errors_mark) begin
			tests_failed++;
			$display("Test %0d %s: FAIL", tests_run, name);
		end else begin
			$display("Test %0d %s: PASS", tests_run, name);
		end
		errors_mark = total_errors;
	endtask

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
	import axi_pkg::*;
	import mem_pkg::*;
;

	localparam int NUM_MASTERS = 2;
	localparam int MEM_WORDS = 256;
	// Well above all burst beats plus arbitration and back-pressure
	localparam int MAX_CYCLES = 4000;

	logic                   aclk;
	logic                   aresetn;
	axi_aw_t                s_aw [NUM_MASTERS];
	axi_w_t                 s_w [NUM_MASTERS];
	axi_ar_t                s_ar [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] s_bready;
	logic [NUM_MASTERS-1:0] s_rready;
	axi_b_t                 s_b [NUM_MASTERS];
	axi_r_t                 s_r [NUM_MASTERS];
	logic [NUM_MASTERS-1:0] s_awready;
	logic [NUM_MASTERS-1:0] s_wready;
	logic [NUM_MASTERS-1:0] s_arready;

	// RAM model and per-requester burst buffers
	logic [DATA_WIDTH-1:0] model [MEM_WORDS];
	logic [DATA_WIDTH-1:0] wdata [NUM_MASTERS][16];
	logic [STRB_WIDTH-1:0] wstrb [NUM_MASTERS][16];
	logic [DATA_WIDTH-1:0] exp_rdata [NUM_MASTERS][16];
	integer seed;
	int cycles;

	axi_mem_sys #(
		.NUM_MASTERS(NUM_MASTERS),
		.MEM_WORDS  (MEM_WORDS)
	) dut0 (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.s_aw      (s_aw),
		.s_w       (s_w),
		.s_ar      (s_ar),
		.s_bready  (s_bready),
		.s_rready  (s_rready),
		.s_b       (s_b),
		.s_r       (s_r),
		.s_awready (s_awready),
		.s_wready  (s_wready),
		.s_arready (s_arready)
	);

	tb_checker #(
		.NUM_MASTERS(NUM_MASTERS)
	) chk0 (
		.aclk     (aclk),
		.aresetn  (aresetn),
		.s_b      (s_b),
		.s_bready (s_bready),
		.s_r      (s_r),
		.s_rready (s_rready)
	);

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge aclk);
			cycles++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// Expected response of a burst; writes update the model, reads fill exp_rdata
	function automatic axi_resp_e ref_burst(input int m, input logic wr,
			input logic [ADDR_WIDTH-1:0] addr, input int beats, input axi_burst_e burst);
		int idx;
		idx = int'((addr >> WORD_LSB) % MEM_WORDS);
		for (int i = 0; i < beats; i++) begin
			if (burst != INCR) begin
				exp_rdata[m][i] = '0;
			end else if (wr) begin
				for (int b = 0; b < STRB_WIDTH; b++) begin
					if (wstrb[m][i][b]) begin
						model[idx][8*b +: 8] = wdata[m][i][8*b +: 8];
					end
				end
			end else begin
				exp_rdata[m][i] = model[idx];
			end
			idx = (idx + 1) % MEM_WORDS;
		end
		return (burst == INCR) ? OKAY : SLVERR;
	endfunction

	task automatic fill_data(input int m, input int beats, input logic [STRB_WIDTH-1:0] strb);
		for (int i = 0; i < beats; i++) begin
			wdata[m][i] = $random(seed);
			wstrb[m][i] = strb;
		end
	endtask

	task automatic write_burst(input int m, input logic [ADDR_WIDTH-1:0] addr, input int beats,
			input axi_burst_e burst);
		axi_resp_e resp;
		resp = ref_burst(m, 1'b1, addr, beats, burst);
		chk0.expect_b(m, '{id: ID_WIDTH'(m + 1), resp: resp, valid: 1'b1});
		s_aw[m] <= '{id: ID_WIDTH'(m + 1), addr: addr, len: LEN_WIDTH'(beats - 1),
			size: 3'd2, burst: burst, valid: 1'b1};
		do @(posedge aclk); while (!s_awready[m]);
		s_aw[m].valid <= 1'b0;
		for (int i = 0; i < beats; i++) begin
			s_w[m] <= '{id: ID_WIDTH'(m + 1), data: wdata[m][i], strb: wstrb[m][i],
				last: (i == beats - 1), valid: 1'b1};
			do @(posedge aclk); while (!s_wready[m]);
		end
		s_w[m].valid <= 1'b0;
		s_bready[m] <= 1'b1;
		do @(posedge aclk); while (!s_b[m].valid);
		s_bready[m] <= 1'b0;
	endtask

	task automatic read_burst(input int m, input logic [ADDR_WIDTH-1:0] addr, input int beats,
			input axi_burst_e burst, input logic backpressure);
		axi_resp_e resp;
		logic done;
		resp = ref_burst(m, 1'b0, addr, beats, burst);
		for (int i = 0; i < beats; i++) begin
			chk0.expect_r(m, '{id: ID_WIDTH'(m + 1), data: exp_rdata[m][i], resp: resp,
				last: (i == beats - 1), valid: 1'b1});
		end
		s_ar[m] <= '{id: ID_WIDTH'(m + 1), addr: addr, len: LEN_WIDTH'(beats - 1),
			size: 3'd2, burst: burst, valid: 1'b1};
		do @(posedge aclk); while (!s_arready[m]);
		s_ar[m].valid <= 1'b0;
		s_rready[m] <= backpressure ? 1'($random(seed)) : 1'b1;
		done = 1'b0;
		while (!done) begin
			@(posedge aclk);
			if (s_r[m].valid && s_rready[m] && s_r[m].last) begin
				done = 1'b1;
			end
			if (done) begin
				s_rready[m] <= 1'b0;
			end else begin
				s_rready[m] <= backpressure ? 1'($random(seed)) : 1'b1;
			end
		end
	endtask

	task automatic contend_writes(input int m, input logic [ADDR_WIDTH-1:0] base);
		for (int k = 0; k < 4; k++) begin
			fill_data(m, 2, 4'hF);
			write_burst(m, base + ADDR_WIDTH'(16 * k), 2, INCR);
		end
	endtask

	// Let the checker see the last handshake, then resume on a rising edge
	task automatic finish_test(input string name);
		@(negedge aclk);
		chk0.end_test(name);
		@(posedge aclk);
	endtask

	initial begin
		seed = 28;
		aresetn = 1'b0;
		for (int i = 0; i < NUM_MASTERS; i++) begin
			s_aw[i] = '0;
			s_w[i] = '0;
			s_ar[i] = '0;
		end
		s_bready = '0;
		s_rready = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			model[i] = '0;
		end
		repeat (10) @(posedge aclk);
		aresetn <= 1'b1;
		@(posedge aclk);

		fill_data(0, 4, 4'hF);
		write_burst(0, 32'h000, 4, INCR);
		read_burst(0, 32'h000, 4, INCR, 1'b0);
		finish_test("incr write and read back");

		for (int i = 0; i < 4; i++) begin
			wdata[0][i] = 32'h0101_0101 * (i + 1);
			wstrb[0][i] = 4'hF;
		end
		write_burst(0, 32'h040, 4, INCR);
		fill_data(0, 4, 4'hF);
		wstrb[0][0] = 4'b0001;
		wstrb[0][1] = 4'b0110;
		wstrb[0][2] = 4'b1000;
		wstrb[0][3] = 4'b1010;
		write_burst(0, 32'h040, 4, INCR);
		read_burst(0, 32'h040, 4, INCR, 1'b0);
		finish_test("partial strobes");

		chk0.set_alternation(1'b1);
		fork
			contend_writes(0, 32'h100);
			contend_writes(1, 32'h200);
		join
		chk0.set_alternation(1'b0);
		for (int k = 0; k < 4; k++) begin
			read_burst(0, 32'h100 + ADDR_WIDTH'(16 * k), 2, INCR, 1'b0);
			read_burst(1, 32'h200 + ADDR_WIDTH'(16 * k), 2, INCR, 1'b0);
		end
		finish_test("round robin contention");

		fill_data(1, 8, 4'hF);
		write_burst(1, 32'h300, 8, INCR);
		read_burst(1, 32'h300, 8, INCR, 1'b1);
		finish_test("read back-pressure");

		// FIXED write must leave test 1 data in place
		fill_data(0, 4, 4'hF);
		write_burst(0, 32'h000, 4, FIXED);
		read_burst(0, 32'h000, 4, INCR, 1'b0);
		read_burst(1, 32'h000, 4, WRAP, 1'b0);
		finish_test("burst type check");

		fill_data(0, 4, 4'hF);
		fork
			write_burst(0, 32'h380, 4, INCR);
			read_burst(1, 32'h300, 8, INCR, 1'b0);
		join
		read_burst(0, 32'h380, 4, INCR, 1'b0);
		finish_test("concurrent write and read");

		$display("%0d tests run, %0d failed, %0d mismatches, %0d missing responses",
			chk0.tests_run, chk0.tests_failed, chk0.total_errors, chk0.missing);
		if (chk0.tests_failed == 0 && chk0.total_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
logic/axi_pkg.sv
logic/mem_pkg.sv
logic/rr_arbiter.sv
logic/axi_mux.sv
logic/axi_ram.sv
logic/axi_mem_sys.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== Makefile ====
# Verilator build and run of the shared-memory subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
